// File: Makefile
# Verilator simulation of the convolution layer

TOP = tb_conv_layer

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vlog.f -o sim
	./obj_dir/sim > sim.log 2>&1 || echo "Simulation exited with an error" >> sim.log
	@cat sim.log
	@! grep -q -e "Testbench failed" -e "Simulation exited with an error" sim.log

clean:
	rm -rf obj_dir sim.log

// File: conv_control.sv
`timescale 1ns/1ps

module conv_control import conv_pkg::*;
#(
    parameter int NUM_FILTERS = NUM_FILTERS_DEFAULT
)
(
    input  logic           clk,
    input  logic           reset,
    input  logic           start,
    input  sample_t        sample,
    input  out_t           sum,
    input  logic           sum_valid,
    output logic           loading,
    output logic           img_we,
    output logic           ker_we,
    output logic [4:0]     rd_row,
    output logic [4:0]     img_row,
    output logic [4:0]     img_col,
    output logic           row_valid,
    output logic           row_first,
    output logic           row_last,
    output filter_result_t result,
    output logic           result_valid,
    output logic           done
);

localparam int IMG_LAST  = IMG_SIZE * IMG_SIZE - 1;
localparam int KER_LAST  = KER_SIZE * KER_SIZE - 1;
// KER_SIZE reads, then pipeline drain and restart
localparam int STEP_LAST = KER_SIZE + 3;
localparam int SW        = $clog2(IMG_SIZE * IMG_SIZE);
localparam int WW        = $clog2(NUM_WINDOWS);
localparam int FW        = $clog2(NUM_FILTERS + 1);

conv_phase_t   phase;
logic [SW-1:0] sample_cnt;
logic [4:0]    step;
logic [WW-1:0] win;
logic [FW-1:0] filter_cnt;
logic          accept;
logic          issue;

////////////////////////////////////////////////////////////////////////////
// Load strobes and read addresses
////////////////////////////////////////////////////////////////////////////

assign loading = (phase == PH_IMAGE) || (phase == PH_KERNEL);
assign accept  = loading && sample.valid;
assign img_we  = accept && (phase == PH_IMAGE);
assign ker_we  = accept && (phase == PH_KERNEL);

assign issue = (phase == PH_COMPUTE) && (step < 5'(KER_SIZE));

// Kernel row within the window; image row adds the window's row offset
assign rd_row  = issue ? step : 5'd0;
assign img_row = rd_row + (win[1] ? 5'(STRIDE) : 5'd0);
assign img_col = win[0] ? 5'(STRIDE) : 5'd0;

////////////////////////////////////////////////////////////////////////////
// Sequencer
////////////////////////////////////////////////////////////////////////////

always_ff @(posedge clk)
begin
    if (reset)
    begin
        phase        <= PH_IDLE;
        sample_cnt   <= '0;
        step         <= '0;
        win          <= '0;
        filter_cnt   <= '0;
        row_valid    <= 1'b0;
        row_first    <= 1'b0;
        row_last     <= 1'b0;
        result_valid <= 1'b0;
        done         <= 1'b0;
    end
    else
    begin
        // Row strobes line up with the registered buffer data
        row_valid    <= issue;
        row_first    <= issue && (step == 5'd0);
        row_last     <= issue && (step == 5'(KER_SIZE - 1));
        result_valid <= 1'b0;
        done         <= 1'b0;

        case (phase)
            PH_IDLE:
            begin
                if (start)
                begin
                    phase      <= PH_IMAGE;
                    sample_cnt <= '0;
                    filter_cnt <= '0;
                end
            end
            PH_IMAGE:
            begin
                if (accept)
                begin
                    if (sample_cnt == SW'(IMG_LAST))
                    begin
                        sample_cnt <= '0;
                        phase      <= PH_KERNEL;
                    end
                    else
                    begin
                        sample_cnt <= sample_cnt + 1'b1;
                    end
                end
            end
            PH_KERNEL:
            begin
                if (accept)
                begin
                    if (sample_cnt == SW'(KER_LAST))
                    begin
                        sample_cnt <= '0;
                        step       <= '0;
                        win        <= '0;
                        phase      <= PH_COMPUTE;
                    end
                    else
                    begin
                        sample_cnt <= sample_cnt + 1'b1;
                    end
                end
            end
            PH_COMPUTE:
            begin
                if (step == 5'(STEP_LAST))
                begin
                    step <= '0;
                    win  <= win + 1'b1;
                end
                else
                begin
                    step <= step + 1'b1;
                end

                // Last window sum arrives on the final step
                if (sum_valid && (win == WW'(NUM_WINDOWS - 1)))
                begin
                    result_valid <= 1'b1;
                    phase        <= PH_FINISH;
                end
            end
            PH_FINISH:
            begin
                if (filter_cnt == FW'(NUM_FILTERS - 1))
                begin
                    filter_cnt <= '0;
                    done       <= 1'b1;
                    phase      <= PH_IDLE;
                end
                else
                begin
                    filter_cnt <= filter_cnt + 1'b1;
                    phase      <= PH_KERNEL;
                end
            end
            default:
            begin
                phase <= PH_IDLE;
            end
        endcase
    end
end

// Each window sum lands in its own field
always_ff @(posedge clk)
begin
    if (sum_valid)
        result[win] <= sum;
end

endmodule

// File: conv_layer.sv
`timescale 1ns/1ps

module conv_layer import conv_pkg::*;
#(
    parameter int NUM_FILTERS = NUM_FILTERS_DEFAULT
)
(
    input  logic           clk,
    input  logic           reset,
    input  logic           start,
    input  sample_t        sample,
    output logic           loading,
    output logic           result_valid,
    output logic           done,
    output filter_result_t result
);

logic        img_we;
logic        ker_we;
logic [4:0]  rd_row;
logic [4:0]  img_row;
logic [4:0]  img_col;
logic        row_valid;
logic        row_first;
logic        row_last;
pixel_row_t  img_seg;
weight_row_t ker_seg;
out_t        sum;
logic        sum_valid;

conv_control #(
    .NUM_FILTERS (NUM_FILTERS)
) control_inst (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .sample       (sample),
    .sum          (sum),
    .sum_valid    (sum_valid),
    .loading      (loading),
    .img_we       (img_we),
    .ker_we       (ker_we),
    .rd_row       (rd_row),
    .img_row      (img_row),
    .img_col      (img_col),
    .row_valid    (row_valid),
    .row_first    (row_first),
    .row_last     (row_last),
    .result       (result),
    .result_valid (result_valid),
    .done         (done)
);

row_buffer #(
    .elem_t   (pixel_t),
    .ROWS     (IMG_SIZE),
    .COLS     (IMG_SIZE),
    .KER_SIZE (KER_SIZE)
) img_buf (
    .clk    (clk),
    .we     (img_we),
    .wdata  (sample.value),
    .rd_row (img_row),
    .rd_col (img_col),
    .rd_seg (img_seg)
);

// Kernel is always read from column 0
row_buffer #(
    .elem_t   (weight_t),
    .ROWS     (KER_SIZE),
    .COLS     (KER_SIZE),
    .KER_SIZE (KER_SIZE)
) ker_buf (
    .clk    (clk),
    .we     (ker_we),
    .wdata  (sample.value),
    .rd_row (rd_row),
    .rd_col (5'd0),
    .rd_seg (ker_seg)
);

row_mac mac_inst (
    .clk       (clk),
    .reset     (reset),
    .row_valid (row_valid),
    .row_first (row_first),
    .row_last  (row_last),
    .pix_row   (img_seg),
    .wgt_row   (ker_seg),
    .sum       (sum),
    .sum_valid (sum_valid)
);

endmodule

// File: conv_layer_checker.sv
`timescale 1ns/1ps

module conv_layer_checker
(
    input logic clk,
    input logic reset,
    input logic loading,
    input logic result_valid,
    input logic done
);

// Single-cycle strobes
result_pulse_a : assert property (@(posedge clk) disable iff (reset)
    result_valid |=> !result_valid)
    else $error("result_valid held for more than one cycle");

done_pulse_a : assert property (@(posedge clk) disable iff (reset)
    done |=> !done)
    else $error("done held for more than one cycle");

// Done comes right after the last result
done_order_a : assert property (@(posedge clk) disable iff (reset)
    done |-> $past(result_valid))
    else $error("done without a result_valid on the cycle before");

reset_load_a : assert property (@(posedge clk)
    reset |=> !loading)
    else $error("loading high after a reset cycle");

endmodule

bind conv_layer conv_layer_checker strobe_check
(
    .clk          (clk),
    .reset        (reset),
    .loading      (loading),
    .result_valid (result_valid),
    .done         (done)
);

// File: conv_pkg.sv
package conv_pkg;

////////////////////////////////////////////////////////////////////////////
// Layer geometry
////////////////////////////////////////////////////////////////////////////

localparam int IMG_SIZE            = 28;
localparam int KER_SIZE            = 21;
localparam int STRIDE              = 7;
localparam int NUM_WINDOWS         = 4;
localparam int NUM_FILTERS_DEFAULT = 10;

// Window sum scaling before truncation to out_t
localparam int OUT_SHIFT           = 10;

////////////////////////////////////////////////////////////////////////////
// Data types
////////////////////////////////////////////////////////////////////////////

typedef logic signed [8:0]  pixel_t;
typedef logic signed [8:0]  weight_t;
typedef logic signed [26:0] acc_t;
typedef logic signed [16:0] out_t;

// One KER_SIZE-wide row segment out of a buffer
typedef pixel_t  pixel_row_t  [KER_SIZE];
typedef weight_t weight_row_t [KER_SIZE];

// Pixel or weight depending on the load phase
typedef struct packed {
    logic              valid;
    logic signed [8:0] value;
} sample_t;

typedef enum logic [2:0] {
    PH_IDLE,
    PH_IMAGE,
    PH_KERNEL,
    PH_COMPUTE,
    PH_FINISH
} conv_phase_t;

// Window 0 sits in the top field
typedef out_t [0:NUM_WINDOWS-1] filter_result_t;

endpackage

// File: row_buffer.sv
`timescale 1ns/1ps

module row_buffer
#(
    parameter type elem_t   = logic,
    parameter int  ROWS     = 28,
    parameter int  COLS     = 28,
    parameter int  KER_SIZE = 21
)
(
    input  logic       clk,
    input  logic       we,
    input  elem_t      wdata,
    input  logic [4:0] rd_row,
    input  logic [4:0] rd_col,
    output elem_t      rd_seg [KER_SIZE]
);

localparam int RW = $clog2(ROWS);
localparam int CW = $clog2(COLS);

elem_t mem [ROWS][COLS];

// Raster write position
logic [RW-1:0] wr_row = '0;
logic [CW-1:0] wr_col = '0;

always_ff @(posedge clk)
begin
    if (we)
    begin
        mem[wr_row][wr_col] <= wdata;
    end
end

// Wraps to the first entry after the last one
always_ff @(posedge clk)
begin
    if (we)
    begin
        if (wr_col == CW'(COLS - 1))
        begin
            wr_col <= '0;
            if (wr_row == RW'(ROWS - 1))
                wr_row <= '0;
            else
                wr_row <= wr_row + 1'b1;
        end
        else
        begin
            wr_col <= wr_col + 1'b1;
        end
    end
end

// Segment read, one cycle after the address
always_ff @(posedge clk)
begin
    for (int k = 0; k < KER_SIZE; k++)
        rd_seg[k] <= mem[rd_row][int'(rd_col) + k];
end

endmodule

// File: row_mac.sv
`timescale 1ns/1ps

module row_mac import conv_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        row_valid,
    input  logic        row_first,
    input  logic        row_last,
    input  pixel_row_t  pix_row,
    input  weight_row_t wgt_row,
    output out_t        sum,
    output logic        sum_valid
);

acc_t row_sum;
acc_t prod_sum;
acc_t acc;

logic valid_d1;
logic first_d1;
logic last_d1;
logic last_d2;

// Dot product of one pixel row and one weight row
always_comb
begin
    row_sum = '0;
    for (int k = 0; k < KER_SIZE; k++)
        row_sum = row_sum + acc_t'(pix_row[k]) * acc_t'(wgt_row[k]);
end

////////////////////////////////////////////////////////////////////////////
// Datapath
////////////////////////////////////////////////////////////////////////////

always_ff @(posedge clk)
begin
    prod_sum <= row_sum;

    // First row of a window reloads, so windows may follow back to back
    if (first_d1)
        acc <= prod_sum;
    else if (valid_d1)
        acc <= acc + prod_sum;

    // Arithmetic shift floors toward negative infinity
    sum <= out_t'(acc >>> OUT_SHIFT);
end

////////////////////////////////////////////////////////////////////////////
// Control pipeline
////////////////////////////////////////////////////////////////////////////

always_ff @(posedge clk)
begin
    if (reset)
    begin
        valid_d1  <= 1'b0;
        first_d1  <= 1'b0;
        last_d1   <= 1'b0;
        last_d2   <= 1'b0;
        sum_valid <= 1'b0;
    end
    else
    begin
        valid_d1  <= row_valid;
        first_d1  <= row_valid && row_first;
        last_d1   <= row_valid && row_last;
        last_d2   <= last_d1;
        sum_valid <= last_d2;
    end
end

endmodule

// File: tb_conv_layer.sv
`timescale 1ns/1ps

module tb_conv_layer import conv_pkg::*;
;

localparam int NUM_FILTERS  = NUM_FILTERS_DEFAULT;
localparam int IMG_SAMPLES  = IMG_SIZE * IMG_SIZE;
localparam int KER_SAMPLES  = KER_SIZE * KER_SIZE;
localparam int LOAD_SAMPLES = IMG_SAMPLES + NUM_FILTERS * KER_SAMPLES;
// Six runs in all with twice the sample count for gapped loads
localparam int RUN_BUDGET   = 2 * LOAD_SAMPLES + NUM_FILTERS * (4 * (KER_SIZE + 4) + 2) + 100;
localparam int MAX_CYCLES   = 6 * RUN_BUDGET + 1000;

logic           clk;
logic           reset;
logic           start;
sample_t        sample;
logic           loading;
logic           result_valid;
logic           done;
filter_result_t result;

int img [IMG_SAMPLES];
int ker [NUM_FILTERS][KER_SAMPLES];

int check_cnt  = 0;
int err_cnt    = 0;
int strobe_cnt = 0;
int done_cnt   = 0;
int wait_cnt   = 0;
int cycle_cnt  = 0;
bit noise_on   = 1'b0;

conv_layer #(
    .NUM_FILTERS (NUM_FILTERS)
) conv_layer_inst (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .sample       (sample),
    .loading      (loading),
    .result_valid (result_valid),
    .done         (done),
    .result       (result)
);

initial
begin
    clk = 1'b0;
    forever #20 clk = ~clk;
end

always @(posedge clk)
begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES)
    begin
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("Testbench failed");
        $finish;
    end
end

////////////////////////////////////////////////////////////////////////////
// Helpers
////////////////////////////////////////////////////////////////////////////

task automatic check_value(input string what, input int actual, input int expected);
    check_cnt++;
    if (actual !== expected)
    begin
        err_cnt++;
        $display("FAIL at %0t: %s, got %0d, expected %0d", $time, what, actual, expected);
    end
endtask

// Reference window sum floored toward negative infinity and cut to 17 bits
function automatic int window_expect(input int f, input int w);
    int   r0;
    int   c0;
    int   acc;
    int   q;
    out_t scaled;
    r0  = (w / 2) * STRIDE;
    c0  = (w % 2) * STRIDE;
    acc = 0;
    for (int i = 0; i < KER_SIZE; i++)
        for (int j = 0; j < KER_SIZE; j++)
            acc += img[(r0 + i) * IMG_SIZE + c0 + j] * ker[f][i * KER_SIZE + j];
    q = acc / (1 << OUT_SHIFT);
    if ((acc < 0) && (q * (1 << OUT_SHIFT) != acc))
        q = q - 1;
    scaled = out_t'(q);
    return int'(scaled);
endfunction

// Note strobes on the falling edge and then drive idle or noise
task automatic next_cycle();
    @(negedge clk);
    if (result_valid)
        strobe_cnt++;
    if (done)
        done_cnt++;
    start        = 1'b0;
    sample.valid = noise_on;
    sample.value = 9'($urandom);
endtask

task automatic send_sample(input int value, input int gap_pct);
    bit sent;
    sent = 1'b0;
    while (!sent)
    begin
        next_cycle();
        sample.valid = (int'($urandom_range(99)) >= gap_pct);
        sample.value = 9'(value);
        if (sample.valid && !loading)
            wait_cnt++;
        sent = sample.valid && loading;
    end
endtask

task automatic fill_random();
    foreach (img[i])
        img[i] = int'($urandom_range(511)) - 256;
    foreach (ker[f, i])
        ker[f][i] = int'($urandom_range(511)) - 256;
endtask

// One full layer pass with every filter checked against the model
task automatic run_layer(input int gap_pct);
    strobe_cnt = 0;
    done_cnt   = 0;
    wait_cnt   = 0;
    next_cycle();
    start = 1'b1;
    for (int i = 0; i < IMG_SAMPLES; i++)
        send_sample(img[i], gap_pct);
    for (int f = 0; f < NUM_FILTERS; f++)
    begin
        for (int i = 0; i < KER_SAMPLES; i++)
            send_sample(ker[f][i], gap_pct);
        do
            next_cycle();
        while (!result_valid);
        check_value($sformatf("loading at filter %0d result", f), loading, 0);
        for (int w = 0; w < NUM_WINDOWS; w++)
            check_value($sformatf("filter %0d window %0d", f, w),
                        int'(result[w]), window_expect(f, w));
    end
    do
        next_cycle();
    while (!done);
endtask

task automatic report_test(input string name, input int errs_before);
    $display("%-20s finished, %0d new errors", name, err_cnt - errs_before);
endtask

////////////////////////////////////////////////////////////////////////////
// Tests
////////////////////////////////////////////////////////////////////////////

task automatic test_max_values();
    int errs;
    errs = err_cnt;
    foreach (img[i])
        img[i] = 255;
    foreach (ker[f, i])
        ker[f][i] = 255;
    run_layer(0);
    for (int w = 0; w < NUM_WINDOWS; w++)
        check_value($sformatf("full-scale window %0d", w), int'(result[w]),
                    (KER_SAMPLES * 255 * 255) >>> OUT_SHIFT);
    report_test("max_values", errs);
endtask

task automatic test_random_gaps();
    int errs;
    errs = err_cnt;
    fill_random();
    run_layer(30);
    report_test("random_gaps", errs);
endtask

task automatic test_negative_sums();
    int errs;
    errs = err_cnt;
    foreach (img[i])
        img[i] = 1;
    foreach (ker[f, i])
        ker[f][i] = -16 * f;
    // Single -1 tap on a pixel of 1
    ker[0][0] = -1;
    run_layer(0);
    report_test("negative_sums", errs);
endtask

task automatic test_strobe_counts();
    int errs;
    errs = err_cnt;
    fill_random();
    run_layer(0);
    check_value("result strobes", strobe_cnt, NUM_FILTERS);
    check_value("done pulses", done_cnt, 1);
    check_value("cycles with loading low during load", wait_cnt, 0);
    repeat (10)
    begin
        next_cycle();
        check_value("loading after done", loading, 0);
    end
    check_value("strobes after done", strobe_cnt, NUM_FILTERS);
    report_test("strobe_counts", errs);
endtask

task automatic test_ignore_restart();
    int errs;
    errs     = err_cnt;
    noise_on = 1'b1;
    fill_random();
    run_layer(20);
    fill_random();
    repeat (20)
        next_cycle();
    run_layer(0);
    noise_on = 1'b0;
    report_test("ignore_restart", errs);
endtask

initial
begin
    void'($urandom(32'h8133_658d));
    reset        = 1'b1;
    start        = 1'b0;
    sample.valid = 1'b0;
    sample.value = '0;
    repeat (4)
        @(negedge clk);
    reset = 1'b0;

    test_max_values();
    test_random_gaps();
    test_negative_sums();
    test_strobe_counts();
    test_ignore_restart();

    $display("Summary: %0d checks, %0d errors", check_cnt, err_cnt);
    if (err_cnt == 0)
        $display("Testbench passed");
    else
        $display("Testbench failed");
    $finish;
end

endmodule

// File: vlog.f
conv_pkg.sv
row_buffer.sv
row_mac.sv
conv_control.sv
conv_layer.sv
conv_layer_checker.sv
tb_conv_layer.sv
